//--- src/arcade_io_pkg.sv
// Joystick word union, keyboard button indices, download index and reset constants
package arcade_io_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Joystick word views
	////////////////////////////////////////////////////////////////////////////

	// USB pad as delivered by the host framework
	typedef struct packed {
		logic [5:0] unused;
		logic       pause;
		logic       start2;
		logic       coin;
		logic       start1;
		logic       btn_b;
		logic       btn_a;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} usb_pad_t;

	// DB15 pad through the SNAC port
	typedef struct packed {
		logic [3:0] unused_hi;
		logic       select;
		logic       start;
		logic [2:0] unused_mid;
		logic       btn_c;
		logic       btn_b;
		logic       btn_a;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} db15_pad_t;

	// Same 16 bits, decoded by source type
	typedef union packed {
		usb_pad_t  usb;
		db15_pad_t db15;
	} joy_word_u;

	////////////////////////////////////////////////////////////////////////////
	// Keyboard button vector
	////////////////////////////////////////////////////////////////////////////

	localparam int KB_BUTTONS = 12;

	localparam int KB_UP      = 0;
	localparam int KB_DOWN    = 1;
	localparam int KB_LEFT    = 2;
	localparam int KB_RIGHT   = 3;
	localparam int KB_SHOT    = 4;
	localparam int KB_JUMP    = 5;
	localparam int KB_START1  = 6;
	localparam int KB_START2  = 7;
	localparam int KB_COIN1   = 8;
	localparam int KB_COIN2   = 9;
	localparam int KB_PAUSE   = 10;
	localparam int KB_SERVICE = 11;

	// Download index reserved for DIP switch data
	localparam logic [7:0] DIP_DOWNLOAD_INDEX = 8'd254;

	// Reset values
	localparam logic [7:0] DIP_RESET_VALUE = 8'hFF;
	// Active-low word, all released
	localparam logic [7:0] PLAYER_IDLE     = 8'hFF;

endpackage

//--- src/ps2_button_decoder.sv
// PS/2 key event decoder holding twelve keyboard button levels
`timescale 1ns/1ps

module ps2_button_decoder
	import arcade_io_pkg::*;
(
	input  logic                  MS_CLK,
	input  logic                  arst_n,
	input  logic [10:0]           ps2_key,
	output logic [KB_BUTTONS-1:0] kb_buttons
);

	// Event fields of the key word
	logic       key_toggle;
	logic       key_pressed;
	logic [7:0] key_code;

	// Toggle bit seen on the previous clock
	logic       toggle_q;
	logic       key_event;

	assign key_toggle  = ps2_key[10];
	assign key_pressed = ps2_key[9];
	assign key_code    = ps2_key[7:0];

	// New event whenever the toggle flips
	assign key_event   = key_toggle ^ toggle_q;

	always_ff @(posedge MS_CLK or negedge arst_n) begin
		if (!arst_n) begin
			toggle_q   <= 1'b0;
			kb_buttons <= '0;
		end else begin
			toggle_q <= key_toggle;
			if (key_event) begin
				// Make sets the button, break clears it
				case (key_code)
					// Number row 1 and 2
					8'h16: kb_buttons[KB_START1]  <= key_pressed;
					8'h1E: kb_buttons[KB_START2]  <= key_pressed;
					// Number row 5 and 6
					8'h2E: kb_buttons[KB_COIN1]   <= key_pressed;
					8'h36: kb_buttons[KB_COIN2]   <= key_pressed;
					// Key 9
					8'h46: kb_buttons[KB_SERVICE] <= key_pressed;
					// Key P
					8'h4D: kb_buttons[KB_PAUSE]   <= key_pressed;
					// Cursor block
					8'h75: kb_buttons[KB_UP]      <= key_pressed;
					8'h72: kb_buttons[KB_DOWN]    <= key_pressed;
					8'h6B: kb_buttons[KB_LEFT]    <= key_pressed;
					8'h74: kb_buttons[KB_RIGHT]   <= key_pressed;
					// Ctrl fires, alt jumps
					8'h14: kb_buttons[KB_SHOT]    <= key_pressed;
					8'h11: kb_buttons[KB_JUMP]    <= key_pressed;
					// Anything else leaves the buttons alone
					default: ;
				endcase
			end
		end
	end

endmodule

//--- src/dip_switch_bank.sv
// DIP switch byte storage loaded from the download stream
`timescale 1ns/1ps

module dip_switch_bank
	import arcade_io_pkg::*;
#(
	parameter int DIP_BANKS = 2
) (
	input  logic                   MS_CLK,
	input  logic                   arst_n,
	input  logic                   ioctl_wr,
	input  logic [7:0]             ioctl_index,
	input  logic [24:0]            ioctl_addr,
	input  logic [7:0]             ioctl_dout,
	output logic [DIP_BANKS*8-1:0] dip_bytes
);

	// Write aimed at the DIP area at all
	logic dip_wr;

	assign dip_wr = ioctl_wr && (ioctl_index == DIP_DOWNLOAD_INDEX);

	// One byte lane per stored bank, byte 0 in the low bits
	always_ff @(posedge MS_CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DIP_BANKS; i++) begin
				dip_bytes[i*8 +: 8] <= DIP_RESET_VALUE;
			end
		end else if (dip_wr) begin
			// Addresses past the last bank match no lane and drop out
			for (int i = 0; i < DIP_BANKS; i++) begin
				if (ioctl_addr == 25'(i)) begin
					dip_bytes[i*8 +: 8] <= ioctl_dout;
				end
			end
		end
	end

endmodule

//--- src/player_input_mapper.sv
// Merge of keyboard, USB and DB15 controls into player words and pause request
`timescale 1ns/1ps

module player_input_mapper
	import arcade_io_pkg::*;
(
	input  logic                  MS_CLK,
	input  logic                  arst_n,
	input  logic [KB_BUTTONS-1:0] kb_buttons,
	input  joy_word_u             joystick_0,
	input  joy_word_u             joystick_1,
	input  joy_word_u             db15_1,
	input  joy_word_u             db15_2,
	input  logic [1:0]            snac_dev,
	output logic [7:0]            player1,
	output logic [7:0]            player2,
	output logic                  pause_request
);

	// DB15 words after the SNAC enables
	joy_word_u  db1;
	joy_word_u  db2;

	// Active-high merged controls
	logic [7:0] p1_act;
	logic [7:0] p2_act;
	logic       pause_act;

	assign db1 = snac_dev[0] ? db15_1 : '0;
	assign db2 = snac_dev[1] ? db15_2 : '0;

	////////////////////////////////////////////////////////////////////////////
	// Player 1: start2 start1 jump shot down up left right
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		p1_act[0] = kb_buttons[KB_RIGHT] | joystick_0.usb.right | db1.db15.right;
		p1_act[1] = kb_buttons[KB_LEFT]  | joystick_0.usb.left  | db1.db15.left;
		p1_act[2] = kb_buttons[KB_UP]    | joystick_0.usb.up    | db1.db15.up;
		p1_act[3] = kb_buttons[KB_DOWN]  | joystick_0.usb.down  | db1.db15.down;
		p1_act[4] = kb_buttons[KB_SHOT]  | joystick_0.usb.btn_a | db1.db15.btn_a;
		p1_act[5] = kb_buttons[KB_JUMP]  | joystick_0.usb.btn_b | db1.db15.btn_b;
		// Either USB pad may start
		p1_act[6] = kb_buttons[KB_START1] | db1.db15.start
			| joystick_0.usb.start1 | joystick_1.usb.start1;
		// DB15-1 button C doubles as start 2 for a single pad
		p1_act[7] = kb_buttons[KB_START2] | db2.db15.start | db1.db15.btn_c
			| joystick_0.usb.start2 | joystick_1.usb.start2;
	end

	////////////////////////////////////////////////////////////////////////////
	// Player 2: coin2 coin1 jump shot down up left right
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		p2_act[0] = kb_buttons[KB_RIGHT] | joystick_1.usb.right | db2.db15.right;
		p2_act[1] = kb_buttons[KB_LEFT]  | joystick_1.usb.left  | db2.db15.left;
		p2_act[2] = kb_buttons[KB_UP]    | joystick_1.usb.up    | db2.db15.up;
		p2_act[3] = kb_buttons[KB_DOWN]  | joystick_1.usb.down  | db2.db15.down;
		p2_act[4] = kb_buttons[KB_SHOT]  | joystick_1.usb.btn_a | db2.db15.btn_a;
		p2_act[5] = kb_buttons[KB_JUMP]  | joystick_1.usb.btn_b | db2.db15.btn_b;
		// Coins follow the pad of each port, select on DB15
		p2_act[6] = kb_buttons[KB_COIN1] | db1.db15.select | joystick_0.usb.coin;
		p2_act[7] = kb_buttons[KB_COIN2] | db2.db15.select | joystick_1.usb.coin;
	end

	// Pause stays active high, start plus A on a DB15 pad
	assign pause_act = kb_buttons[KB_PAUSE]
		| joystick_0.usb.pause | joystick_1.usb.pause
		| (db1.db15.start & db1.db15.btn_a)
		| (db2.db15.start & db2.db15.btn_a);

	// Registered active-low words for the game
	always_ff @(posedge MS_CLK or negedge arst_n) begin
		if (!arst_n) begin
			player1       <= PLAYER_IDLE;
			player2       <= PLAYER_IDLE;
			pause_request <= 1'b0;
		end else begin
			player1       <= ~p1_act;
			player2       <= ~p2_act;
			pause_request <= pause_act;
		end
	end

endmodule

//--- src/video_output_stage.sv
// Colour expansion, blank and sync polarity fix and aspect-ratio selection
`timescale 1ns/1ps

module video_output_stage (
	input  logic        MS_CLK,
	input  logic        arst_n,
	input  logic [3:0]  core_r,
	input  logic [3:0]  core_g,
	input  logic [3:0]  core_b,
	input  logic        core_hblank_n,
	input  logic        core_vblank_n,
	input  logic        core_hsync,
	input  logic        core_vsync_n,
	input  logic [1:0]  aspect_sel,
	input  logic        vertical,
	output logic [23:0] rgb,
	output logic        hblank,
	output logic        vblank,
	output logic        hsync,
	output logic        vsync,
	output logic [11:0] video_arx,
	output logic [11:0] video_ary
);

	// Next aspect pair
	logic [11:0] arx_d;
	logic [11:0] ary_d;

	////////////////////////////////////////////////////////////////////////////
	// Aspect ratio
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		if (aspect_sel == 2'd0) begin
			// Native 4:3, turned for a vertical monitor
			arx_d = vertical ? 12'd3 : 12'd4;
			ary_d = vertical ? 12'd4 : 12'd3;
		end else begin
			// Custom ratio slot, ary of zero marks it
			arx_d = {10'd0, aspect_sel} - 12'd1;
			ary_d = 12'd0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output registers
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge MS_CLK or negedge arst_n) begin
		if (!arst_n) begin
			rgb       <= '0;
			hblank    <= 1'b1;
			vblank    <= 1'b1;
			hsync     <= 1'b0;
			vsync     <= 1'b0;
			video_arx <= 12'd4;
			video_ary <= 12'd3;
		end else begin
			// Nibble repeated so 0 maps to 00h and F to FFh
			rgb       <= {core_r, core_r, core_g, core_g, core_b, core_b};
			// Core blanks are active low
			hblank    <= ~core_hblank_n;
			vblank    <= ~core_vblank_n;
			// Hsync already in framework polarity
			hsync     <= core_hsync;
			vsync     <= ~core_vsync_n;
			video_arx <= arx_d;
			video_ary <= ary_d;
		end
	end

endmodule

//--- src/arcade_io_top.sv
// Top level of the input and video glue with decoder, DIP bank, mapper and video stage
`timescale 1ns/1ps

module arcade_io_top
	import arcade_io_pkg::*;
#(
	parameter int DIP_BANKS = 2
) (
	input  logic                   MS_CLK,
	input  logic                   arst_n,
	// Keyboard
	input  logic [10:0]            ps2_key,
	// Download port
	input  logic                   ioctl_wr,
	input  logic [7:0]             ioctl_index,
	input  logic [24:0]            ioctl_addr,
	input  logic [7:0]             ioctl_dout,
	// Joysticks
	input  joy_word_u              joystick_0,
	input  joy_word_u              joystick_1,
	input  joy_word_u              db15_1,
	input  joy_word_u              db15_2,
	input  logic [1:0]             snac_dev,
	// Core video
	input  logic [3:0]             core_r,
	input  logic [3:0]             core_g,
	input  logic [3:0]             core_b,
	input  logic                   core_hblank_n,
	input  logic                   core_vblank_n,
	input  logic                   core_hsync,
	input  logic                   core_vsync_n,
	input  logic [1:0]             aspect_sel,
	input  logic                   vertical,
	// Game side
	output logic [7:0]             player1,
	output logic [7:0]             player2,
	output logic                   pause_request,
	output logic [DIP_BANKS*8-1:0] dip_bytes,
	// Framework video
	output logic [23:0]            rgb,
	output logic                   hblank,
	output logic                   vblank,
	output logic                   hsync,
	output logic                   vsync,
	output logic [11:0]            video_arx,
	output logic [11:0]            video_ary
);

	// Held keyboard levels, one cycle behind the key event
	logic [KB_BUTTONS-1:0] kb_buttons;

	ps2_button_decoder u_kbd (
		.MS_CLK     (MS_CLK),
		.arst_n     (arst_n),
		.ps2_key    (ps2_key),
		.kb_buttons (kb_buttons)
	);

	dip_switch_bank #(
		.DIP_BANKS (DIP_BANKS)
	) u_dip (
		.MS_CLK      (MS_CLK),
		.arst_n      (arst_n),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.dip_bytes   (dip_bytes)
	);

	// Keyboard path totals two cycles, joysticks one
	player_input_mapper u_map (
		.MS_CLK        (MS_CLK),
		.arst_n        (arst_n),
		.kb_buttons    (kb_buttons),
		.joystick_0    (joystick_0),
		.joystick_1    (joystick_1),
		.db15_1        (db15_1),
		.db15_2        (db15_2),
		.snac_dev      (snac_dev),
		.player1       (player1),
		.player2       (player2),
		.pause_request (pause_request)
	);

	video_output_stage u_vid (
		.MS_CLK        (MS_CLK),
		.arst_n        (arst_n),
		.core_r        (core_r),
		.core_g        (core_g),
		.core_b        (core_b),
		.core_hblank_n (core_hblank_n),
		.core_vblank_n (core_vblank_n),
		.core_hsync    (core_hsync),
		.core_vsync_n  (core_vsync_n),
		.aspect_sel    (aspect_sel),
		.vertical      (vertical),
		.rgb           (rgb),
		.hblank        (hblank),
		.vblank        (vblank),
		.hsync         (hsync),
		.vsync         (vsync),
		.video_arx     (video_arx),
		.video_ary     (video_ary)
	);

endmodule

//--- tests/tb_arcade_io_model.svh
// Reference model functions for key mapping, DB15 gating, player words, pause, colour and aspect
`ifndef TB_ARCADE_IO_MODEL_SVH
`define TB_ARCADE_IO_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Keyboard and joystick rules
////////////////////////////////////////////////////////////////////////////

// Button slot for a PS/2 code, -1 when the code is not mapped
function automatic int key_slot(input logic [7:0] code);
	case (code)
		8'h16: return KB_START1;
		8'h1E: return KB_START2;
		8'h2E: return KB_COIN1;
		8'h36: return KB_COIN2;
		8'h46: return KB_SERVICE;
		8'h4D: return KB_PAUSE;
		8'h75: return KB_UP;
		8'h72: return KB_DOWN;
		8'h6B: return KB_LEFT;
		8'h74: return KB_RIGHT;
		8'h14: return KB_SHOT;
		8'h11: return KB_JUMP;
		default: return -1;
	endcase
endfunction

// SNAC enable off means the port reads as nothing pressed
function automatic logic [15:0] gate_db15(input logic [15:0] word, input logic enable);
	return enable ? word : 16'h0000;
endfunction

// Raw bit positions: USB right 0, left 1, down 2, up 3, A 4, B 5, st1 6, coin 7, st2 8, pause 9
// DB15 C 6, start 10, select 11
function automatic logic [7:0] p1_word(input logic [KB_BUTTONS-1:0] kb,
	input logic [15:0] j0, input logic [15:0] j1, input logic [15:0] d1, input logic [15:0] d2);
	logic [7:0] held;
	held[0] = kb[KB_RIGHT]  | j0[0] | d1[0];
	held[1] = kb[KB_LEFT]   | j0[1] | d1[1];
	held[2] = kb[KB_UP]     | j0[3] | d1[3];
	held[3] = kb[KB_DOWN]   | j0[2] | d1[2];
	held[4] = kb[KB_SHOT]   | j0[4] | d1[4];
	held[5] = kb[KB_JUMP]   | j0[5] | d1[5];
	held[6] = kb[KB_START1] | d1[10] | j0[6] | j1[6];
	held[7] = kb[KB_START2] | d2[10] | d1[6] | j0[8] | j1[8];
	// Game reads active low
	return ~held;
endfunction

function automatic logic [7:0] p2_word(input logic [KB_BUTTONS-1:0] kb,
	input logic [15:0] j0, input logic [15:0] j1, input logic [15:0] d1, input logic [15:0] d2);
	logic [7:0] held;
	held[0] = kb[KB_RIGHT] | j1[0] | d2[0];
	held[1] = kb[KB_LEFT]  | j1[1] | d2[1];
	held[2] = kb[KB_UP]    | j1[3] | d2[3];
	held[3] = kb[KB_DOWN]  | j1[2] | d2[2];
	held[4] = kb[KB_SHOT]  | j1[4] | d2[4];
	held[5] = kb[KB_JUMP]  | j1[5] | d2[5];
	// Coins
	held[6] = kb[KB_COIN1] | d1[11] | j0[7];
	held[7] = kb[KB_COIN2] | d2[11] | j1[7];
	return ~held;
endfunction

function automatic logic pause_level(input logic [KB_BUTTONS-1:0] kb,
	input logic [15:0] j0, input logic [15:0] j1, input logic [15:0] d1, input logic [15:0] d2);
	return kb[KB_PAUSE] | j0[9] | j1[9] | (d1[10] & d1[4]) | (d2[10] & d2[4]);
endfunction

////////////////////////////////////////////////////////////////////////////
// Video rules
////////////////////////////////////////////////////////////////////////////

// Nibble times 17 fills both halves
function automatic logic [23:0] expand_colour(input logic [3:0] r, input logic [3:0] g,
	input logic [3:0] b);
	return {{4'd0, r} * 8'd17, {4'd0, g} * 8'd17, {4'd0, b} * 8'd17};
endfunction

function automatic logic [11:0] aspect_x(input logic [1:0] sel, input logic vert);
	if (sel == 2'd0)
		return vert ? 12'd3 : 12'd4;
	return 12'(sel) - 12'd1;
endfunction

function automatic logic [11:0] aspect_y(input logic [1:0] sel, input logic vert);
	if (sel == 2'd0)
		return vert ? 12'd4 : 12'd3;
	// Custom slot
	return 12'd0;
endfunction

`endif

//--- tests/tb_arcade_io.sv
// Testbench for the arcade I/O glue with xorshift stimulus, reference model and result checks
`timescale 1ns/1ps

module tb_arcade_io
	import arcade_io_pkg::*;
;

	localparam int DIP_BANKS    = 2;
	localparam int RESET_CYCLES = 10;
	// Stimulus length per behavior
	localparam int N_KEYS       = 300;
	localparam int N_USB        = 200;
	localparam int N_DB15       = 200;
	localparam int N_DOWNLOAD   = 200;
	localparam int N_VIDEO      = 200;
	localparam int TOTAL_CYCLES = RESET_CYCLES + N_KEYS + KB_BUTTONS + N_USB + N_DB15
		+ N_DOWNLOAD + N_VIDEO;
	localparam int CYCLE_LIMIT  = 2 * TOTAL_CYCLES;

	// Mapped PS/2 codes
	localparam logic [7:0] KEY_CODES [12] = '{8'h16, 8'h1E, 8'h2E, 8'h36, 8'h46, 8'h4D,
		8'h75, 8'h72, 8'h6B, 8'h74, 8'h14, 8'h11};

	logic                   MS_CLK;
	logic                   arst_n;
	logic [10:0]            ps2_key;
	logic                   ioctl_wr;
	logic [7:0]             ioctl_index;
	logic [24:0]            ioctl_addr;
	logic [7:0]             ioctl_dout;
	joy_word_u              joystick_0;
	joy_word_u              joystick_1;
	joy_word_u              db15_1;
	joy_word_u              db15_2;
	logic [1:0]             snac_dev;
	logic [3:0]             core_r;
	logic [3:0]             core_g;
	logic [3:0]             core_b;
	logic                   core_hblank_n;
	logic                   core_vblank_n;
	logic                   core_hsync;
	logic                   core_vsync_n;
	logic [1:0]             aspect_sel;
	logic                   vertical;
	logic [7:0]             player1;
	logic [7:0]             player2;
	logic                   pause_request;
	logic [DIP_BANKS*8-1:0] dip_bytes;
	logic [23:0]            rgb;
	logic                   hblank;
	logic                   vblank;
	logic                   hsync;
	logic                   vsync;
	logic [11:0]            video_arx;
	logic [11:0]            video_ary;

	// Model state
	logic [KB_BUTTONS-1:0]  model_kb;
	logic                   model_toggle;
	logic [7:0]             model_dip [DIP_BANKS];
	joy_word_u              exp_db1;
	joy_word_u              exp_db2;
	logic [7:0]             exp_p1;
	logic [7:0]             exp_p2;
	logic                   exp_pause;
	logic [23:0]            exp_rgb;
	logic [3:0]             exp_sync;
	logic [11:0]            exp_arx;
	logic [11:0]            exp_ary;

	logic [31:0]            rng_state;
	logic                   key_toggle;
	int                     cycle_count;

	arcade_io_top #(
		.DIP_BANKS (DIP_BANKS)
	) uut (
		.MS_CLK (MS_CLK), .arst_n (arst_n), .ps2_key (ps2_key),
		.ioctl_wr (ioctl_wr), .ioctl_index (ioctl_index), .ioctl_addr (ioctl_addr),
		.ioctl_dout (ioctl_dout),
		.joystick_0 (joystick_0), .joystick_1 (joystick_1),
		.db15_1 (db15_1), .db15_2 (db15_2), .snac_dev (snac_dev),
		.core_r (core_r), .core_g (core_g), .core_b (core_b),
		.core_hblank_n (core_hblank_n), .core_vblank_n (core_vblank_n),
		.core_hsync (core_hsync), .core_vsync_n (core_vsync_n),
		.aspect_sel (aspect_sel), .vertical (vertical),
		.player1 (player1), .player2 (player2), .pause_request (pause_request),
		.dip_bytes (dip_bytes),
		.rgb (rgb), .hblank (hblank), .vblank (vblank), .hsync (hsync), .vsync (vsync),
		.video_arx (video_arx), .video_ary (video_ary)
	);

	`include "tb_arcade_io_model.svh"

	// 100 ns clock
	always #50 MS_CLK = ~MS_CLK;

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting and compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_player(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_dip(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_joy(input string name, input joy_word_u got, input joy_word_u exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_rgb(input string name, input logic [23:0] got, input logic [23:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_aspect(input string name, input logic [11:0] got,
		input logic [11:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	// Run ends at the cycle limit
	always @(posedge MS_CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
			stop_with_failure($sformatf("Timeout, the tests ran past %0d clock cycles",
				CYCLE_LIMIT));
	end

	////////////////////////////////////////////////////////////////////////////
	// Model update and per-cycle comparison
	////////////////////////////////////////////////////////////////////////////

	// Xorshift32
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic reset_model();
		model_kb     = '0;
		model_toggle = 1'b0;
		for (int i = 0; i < DIP_BANKS; i++)
			model_dip[i] = DIP_RESET_VALUE;
	endtask

	// Inputs still hold what the last edge sampled
	task automatic advance_model();
		int slot;
		exp_db1   = gate_db15(db15_1, snac_dev[0]);
		exp_db2   = gate_db15(db15_2, snac_dev[1]);
		// Mapper sees the button state from before this edge
		exp_p1    = p1_word(model_kb, joystick_0, joystick_1, exp_db1, exp_db2);
		exp_p2    = p2_word(model_kb, joystick_0, joystick_1, exp_db1, exp_db2);
		exp_pause = pause_level(model_kb, joystick_0, joystick_1, exp_db1, exp_db2);
		if (ps2_key[10] != model_toggle) begin
			slot = key_slot(ps2_key[7:0]);
			if (slot >= 0)
				model_kb[slot] = ps2_key[9];
		end
		model_toggle = ps2_key[10];
		if (ioctl_wr && ioctl_index == DIP_DOWNLOAD_INDEX) begin
			for (int i = 0; i < DIP_BANKS; i++)
				if (32'(ioctl_addr) == i)
					model_dip[i] = ioctl_dout;
		end
		exp_rgb  = expand_colour(core_r, core_g, core_b);
		// hblank, vblank, hsync, vsync
		exp_sync = {~core_hblank_n, ~core_vblank_n, core_hsync, ~core_vsync_n};
		exp_arx  = aspect_x(aspect_sel, vertical);
		exp_ary  = aspect_y(aspect_sel, vertical);
	endtask

	task automatic compare_outputs();
		check_joy("db15_1 gated", uut.u_map.db1, exp_db1);
		check_joy("db15_2 gated", uut.u_map.db2, exp_db2);
		check_player("player1", player1, exp_p1);
		check_player("player2", player2, exp_p2);
		check_flag("pause_request", pause_request, exp_pause);
		for (int i = 0; i < DIP_BANKS; i++)
			check_dip($sformatf("dip_bytes[%0d]", i), dip_bytes[i*8 +: 8], model_dip[i]);
		check_rgb("rgb", rgb, exp_rgb);
		check_flag("hblank", hblank, exp_sync[3]);
		check_flag("vblank", vblank, exp_sync[2]);
		check_flag("hsync", hsync, exp_sync[1]);
		check_flag("vsync", vsync, exp_sync[0]);
		check_aspect("video_arx", video_arx, exp_arx);
		check_aspect("video_ary", video_ary, exp_ary);
	endtask

	// Check just after the edge, leave 5 ns past it for the next drive
	task automatic next_edge();
		@(posedge MS_CLK);
		#1;
		advance_model();
		compare_outputs();
		#4;
	endtask

	task automatic check_reset_state();
		check_player("player1", player1, PLAYER_IDLE);
		check_player("player2", player2, PLAYER_IDLE);
		check_flag("pause_request", pause_request, 1'b0);
		for (int i = 0; i < DIP_BANKS; i++)
			check_dip($sformatf("dip_bytes[%0d]", i), dip_bytes[i*8 +: 8], DIP_RESET_VALUE);
		check_flag("hblank", hblank, 1'b1);
		check_flag("vblank", vblank, 1'b1);
		check_flag("hsync", hsync, 1'b0);
		check_flag("vsync", vsync, 1'b0);
		check_rgb("rgb", rgb, 24'h000000);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		logic [31:0] r2;
		logic [7:0]  code;
		MS_CLK        = 1'b0;
		arst_n        = 1'b0;
		rng_state     = 32'd95694;
		cycle_count   = 0;
		key_toggle    = 1'b0;
		ps2_key       = '0;
		ioctl_wr      = 1'b0;
		ioctl_index   = '0;
		ioctl_addr    = '0;
		ioctl_dout    = '0;
		joystick_0    = '0;
		joystick_1    = '0;
		db15_1        = '0;
		db15_2        = '0;
		snac_dev      = '0;
		core_r        = '0;
		core_g        = '0;
		core_b        = '0;
		core_hblank_n = 1'b1;
		core_vblank_n = 1'b1;
		core_hsync    = 1'b0;
		core_vsync_n  = 1'b1;
		aspect_sel    = '0;
		vertical      = 1'b0;

		// Reset state
		repeat (RESET_CYCLES) @(posedge MS_CLK);
		#1;
		check_reset_state();
		#4;
		reset_model();
		arst_n = 1'b1;

		// Keyboard events, some codes unmapped, some without a toggle flip
		for (int n = 0; n < N_KEYS; n++) begin
			r = next_rand();
			if (r[3:0] < 4'd12)
				code = KEY_CODES[r[3:0]];
			else
				code = r[15:8];
			if (r[17:16] != 2'b00)
				key_toggle = ~key_toggle;
			ps2_key = {key_toggle, r[20], r[21], code};
			next_edge();
		end
		// Break codes so later words are not masked
		for (int k = 0; k < KB_BUTTONS; k++) begin
			key_toggle = ~key_toggle;
			ps2_key    = {key_toggle, 1'b0, 1'b0, KEY_CODES[k]};
			next_edge();
		end

		// USB pads with DB15 disabled
		for (int n = 0; n < N_USB; n++) begin
			r          = next_rand();
			r2         = next_rand();
			joystick_0 = r[15:0];
			joystick_1 = r[31:16];
			db15_1     = r2[15:0];
			db15_2     = r2[31:16];
			snac_dev   = 2'b00;
			next_edge();
		end

		// DB15 pads gated per port
		joystick_0 = '0;
		joystick_1 = '0;
		for (int n = 0; n < N_DB15; n++) begin
			r        = next_rand();
			r2       = next_rand();
			db15_1   = r[15:0];
			db15_2   = r[31:16];
			snac_dev = r2[1:0];
			next_edge();
		end

		// Download writes, addresses 0 to 3 straddle the last bank
		snac_dev = 2'b00;
		for (int n = 0; n < N_DOWNLOAD; n++) begin
			r           = next_rand();
			r2          = next_rand();
			ioctl_wr    = r[0];
			ioctl_index = r[1] ? DIP_DOWNLOAD_INDEX : r[15:8];
			ioctl_addr  = r[2] ? {23'd0, r[4:3]} : r2[24:0];
			ioctl_dout  = r[31:24];
			next_edge();
		end
		ioctl_wr = 1'b0;

		// Core video
		for (int n = 0; n < N_VIDEO; n++) begin
			r             = next_rand();
			core_r        = r[3:0];
			core_g        = r[7:4];
			core_b        = r[11:8];
			core_hblank_n = r[12];
			core_vblank_n = r[13];
			core_hsync    = r[14];
			core_vsync_n  = r[15];
			aspect_sel    = r[17:16];
			vertical      = r[18];
			next_edge();
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

//--- src.f
+incdir+tests
src/arcade_io_pkg.sv
src/ps2_button_decoder.sv
src/dip_switch_bank.sv
src/player_input_mapper.sv
src/video_output_stage.sv
src/arcade_io_top.sv
tests/tb_arcade_io.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP       ?= tb_arcade_io
FILELIST  ?= src.f
LOG       ?= sim.log
PASS_MSG  := TEST PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
